// ==== include/exu_alu_config.svh ====
// Execution ALU configuration
`ifndef EXU_ALU_CONFIG_SVH
`define EXU_ALU_CONFIG_SVH

`define EXU_XLEN        32
`define EXU_PC_SIZE     32
`define EXU_RFIDX_WIDTH 5
`define EXU_GRP_WIDTH   2
`define EXU_OP_WIDTH    4
`define EXU_MUL_STEPS   32

// Decode groups
`define EXU_GRP_ALU 2'd0
`define EXU_GRP_BJP 2'd1
`define EXU_GRP_MUL 2'd2

// ALU ops, codes with bit 3 set take the immediate as second operand
`define EXU_OP_IMM_BIT 3
`define EXU_OP_ADD  4'h0
`define EXU_OP_SUB  4'h1
`define EXU_OP_XOR  4'h2
`define EXU_OP_OR   4'h3
`define EXU_OP_AND  4'h4
`define EXU_OP_SLL  4'h5
`define EXU_OP_SRL  4'h6
`define EXU_OP_SRA  4'h7
`define EXU_OP_LUI  4'h9
`define EXU_OP_SLT  4'hE
`define EXU_OP_SLTU 4'hF

// Branch and jump ops
`define EXU_OP_BEQ  4'h0
`define EXU_OP_BNE  4'h1
`define EXU_OP_BLT  4'h2
`define EXU_OP_BGE  4'h3
`define EXU_OP_BLTU 4'h4
`define EXU_OP_BGEU 4'h5
`define EXU_OP_JAL  4'h6

// Multiply op
`define EXU_OP_MUL  4'h0

// Datapath functions
`define EXU_DPATH_ADD  4'd0
`define EXU_DPATH_SUB  4'd1
`define EXU_DPATH_XOR  4'd2
`define EXU_DPATH_OR   4'd3
`define EXU_DPATH_AND  4'd4
`define EXU_DPATH_SLL  4'd5
`define EXU_DPATH_SRL  4'd6
`define EXU_DPATH_SRA  4'd7
`define EXU_DPATH_SLT  4'd8
`define EXU_DPATH_SLTU 4'd9

`endif

// ==== logic/exu_alu_pkg.sv ====
// Execution ALU types
`default_nettype none

`include "exu_alu_config.svh"

package exu_alu_pkg;

  typedef logic [`EXU_XLEN-1:0]        xlen_t;
  typedef logic [`EXU_PC_SIZE-1:0]     pc_t;
  typedef logic [`EXU_RFIDX_WIDTH-1:0] rfidx_t;
  typedef logic [`EXU_GRP_WIDTH-1:0]   grp_t;
  typedef logic [`EXU_OP_WIDTH-1:0]    op_t;
  typedef logic [3:0]                  dpath_fn_t;

  ////////////////////////////////////////////////////////////////////////////
  // Records

  typedef struct packed {
    xlen_t  rs1;
    xlen_t  rs2;
    xlen_t  imm;
    pc_t    pc;
    rfidx_t rdidx;
    logic   rdwen;
    logic   ilegl;   // Fetch flagged an illegal instruction
    grp_t   grp;
    op_t    op;
  } exu_issue_t;

  typedef struct packed {
    xlen_t     op1;
    xlen_t     op2;
    dpath_fn_t fn;
  } dpath_req_t;

  typedef struct packed {
    xlen_t wdat;
    logic  err;
    logic  bjp;
    logic  prdt;    // Predicted taken
    logic  rslv;    // Resolved taken
  } unit_rsp_t;

  typedef struct packed {
    pc_t  pc;
    logic pc_vld;
    logic bjp;
    logic prdt;
    logic rslv;
    logic ilegl;
  } exu_cmt_t;

  typedef struct packed {
    xlen_t  wdat;
    rfidx_t rdidx;
  } exu_wbck_t;

  // Multiplier sequencing
  typedef enum logic [1:0] {
    MDV_IDLE,
    MDV_BUSY,
    MDV_DONE
  } mdv_state_e;

endpackage

`default_nettype wire

// ==== logic/exu_alu_dpath.sv ====
// Shared ALU datapath
`timescale 1ns/100ps
`default_nettype none

`include "exu_alu_config.svh"

module exu_alu_dpath (
  input  wire exu_alu_pkg::grp_t       i_grp,
  input  wire exu_alu_pkg::dpath_req_t i_rglr_req,
  input  wire exu_alu_pkg::dpath_req_t i_bjp_req,
  input  wire exu_alu_pkg::dpath_req_t i_mdv_req,
  output exu_alu_pkg::xlen_t           o_res
);
  import exu_alu_pkg::*;

  dpath_req_t          req;
  logic                do_sub;
  logic [`EXU_XLEN:0]  sum;      // Carry out on top
  logic                lt, ltu;
  logic [4:0]          shamt;

  ////////////////////////////////////////////////////////////////////////////
  // Requester select

  always_comb begin
    case (i_grp)
      `EXU_GRP_BJP: req = i_bjp_req;
      `EXU_GRP_MUL: req = i_mdv_req;
      default:      req = i_rglr_req;
    endcase
  end

  // Compares reuse the subtractor
  assign do_sub = (req.fn == `EXU_DPATH_SUB) | (req.fn == `EXU_DPATH_SLT)
                | (req.fn == `EXU_DPATH_SLTU);

  assign sum = {1'b0, req.op1} + {1'b0, (do_sub ? ~req.op2 : req.op2)}
             + {{`EXU_XLEN{1'b0}}, do_sub};

  assign ltu = ~sum[`EXU_XLEN];     // No carry means a borrow
  assign lt  = (req.op1[`EXU_XLEN-1] != req.op2[`EXU_XLEN-1]) ?
               req.op1[`EXU_XLEN-1] : sum[`EXU_XLEN-1];

  assign shamt = req.op2[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // Function mux

  always_comb begin
    case (req.fn)
      `EXU_DPATH_ADD,
      `EXU_DPATH_SUB:  o_res = sum[`EXU_XLEN-1:0];
      `EXU_DPATH_XOR:  o_res = req.op1 ^ req.op2;
      `EXU_DPATH_OR:   o_res = req.op1 | req.op2;
      `EXU_DPATH_AND:  o_res = req.op1 & req.op2;
      `EXU_DPATH_SLL:  o_res = req.op1 << shamt;
      `EXU_DPATH_SRL:  o_res = req.op1 >> shamt;
      `EXU_DPATH_SRA:  o_res = xlen_t'($signed(req.op1) >>> shamt);
      `EXU_DPATH_SLT:  o_res = {{(`EXU_XLEN-1){1'b0}}, lt};
      `EXU_DPATH_SLTU: o_res = {{(`EXU_XLEN-1){1'b0}}, ltu};
      default:         o_res = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/exu_alu_rglr.sv ====
// Regular ALU unit
`timescale 1ns/100ps
`default_nettype none

`include "exu_alu_config.svh"

module exu_alu_rglr (
  input  wire logic                    i_valid,
  output logic                         o_ready,
  input  wire exu_alu_pkg::op_t        i_op,
  input  wire exu_alu_pkg::xlen_t      i_rs1,
  input  wire exu_alu_pkg::xlen_t      i_rs2,
  input  wire exu_alu_pkg::xlen_t      i_imm,
  output exu_alu_pkg::dpath_req_t      o_req,
  input  wire exu_alu_pkg::xlen_t      i_res,
  output logic                         o_rsp_valid,
  input  wire logic                    i_o_ready,
  output exu_alu_pkg::unit_rsp_t       o_rsp
);
  import exu_alu_pkg::*;

  dpath_fn_t fn;
  logic      is_lui;

  assign is_lui = (i_op == `EXU_OP_LUI);

  // Imm forms share the function of their register form
  always_comb begin
    case (i_op)
      `EXU_OP_SUB:  fn = `EXU_DPATH_SUB;
      `EXU_OP_XOR,
      4'hA:         fn = `EXU_DPATH_XOR;
      `EXU_OP_OR,
      4'hB:         fn = `EXU_DPATH_OR;
      `EXU_OP_AND,
      4'hC:         fn = `EXU_DPATH_AND;
      `EXU_OP_SLL,
      4'hD:         fn = `EXU_DPATH_SLL;
      `EXU_OP_SRL:  fn = `EXU_DPATH_SRL;
      `EXU_OP_SRA:  fn = `EXU_DPATH_SRA;
      `EXU_OP_SLT:  fn = `EXU_DPATH_SLT;
      `EXU_OP_SLTU: fn = `EXU_DPATH_SLTU;
      default:      fn = `EXU_DPATH_ADD;     // add, addi and lui
    endcase
  end

  assign o_req.op1 = is_lui ? '0 : i_rs1;
  assign o_req.op2 = i_op[`EXU_OP_IMM_BIT] ? i_imm : i_rs2;
  assign o_req.fn  = fn;

  assign o_rsp_valid = i_valid;
  assign o_ready     = i_o_ready;
  assign o_rsp       = '{wdat: i_res, err: 1'b0, bjp: 1'b0, prdt: 1'b0, rslv: 1'b0};

endmodule

`default_nettype wire

// ==== logic/exu_alu_bjp.sv ====
// Branch and jump unit
`timescale 1ns/100ps
`default_nettype none

`include "exu_alu_config.svh"

module exu_alu_bjp (
  input  wire logic                    i_valid,
  output logic                         o_ready,
  input  wire exu_alu_pkg::op_t        i_op,
  input  wire exu_alu_pkg::xlen_t      i_rs1,
  input  wire exu_alu_pkg::xlen_t      i_rs2,
  input  wire exu_alu_pkg::xlen_t      i_imm,
  input  wire exu_alu_pkg::pc_t        i_pc,
  output exu_alu_pkg::dpath_req_t      o_req,
  input  wire exu_alu_pkg::xlen_t      i_res,
  output logic                         o_rsp_valid,
  input  wire logic                    i_o_ready,
  output exu_alu_pkg::unit_rsp_t       o_rsp
);
  import exu_alu_pkg::*;

  logic  taken;
  logic  res_zero;
  xlen_t link;

  assign res_zero = (i_res == '0);
  assign link     = xlen_t'(i_pc + 4);

  always_comb begin
    o_req.op1 = i_rs1;
    o_req.op2 = i_rs2;
    case (i_op)
      `EXU_OP_BEQ:  begin o_req.fn = `EXU_DPATH_SUB;  taken =  res_zero;  end
      `EXU_OP_BNE:  begin o_req.fn = `EXU_DPATH_SUB;  taken = ~res_zero;  end
      `EXU_OP_BLT:  begin o_req.fn = `EXU_DPATH_SLT;  taken =  i_res[0];  end
      `EXU_OP_BGE:  begin o_req.fn = `EXU_DPATH_SLT;  taken = ~i_res[0];  end
      `EXU_OP_BLTU: begin o_req.fn = `EXU_DPATH_SLTU; taken =  i_res[0];  end
      `EXU_OP_BGEU: begin o_req.fn = `EXU_DPATH_SLTU; taken = ~i_res[0];  end
      default:      begin o_req.fn = `EXU_DPATH_SUB;  taken =  1'b1;      end  // jal
    endcase
  end

  assign o_rsp_valid = i_valid;
  assign o_ready     = i_o_ready;

  assign o_rsp.wdat = link;                   // Link value for jal
  assign o_rsp.err  = 1'b0;
  assign o_rsp.bjp  = 1'b1;
  assign o_rsp.prdt = i_imm[`EXU_XLEN-1];     // Backward target predicted taken
  assign o_rsp.rslv = taken;

endmodule

`default_nettype wire

// ==== logic/exu_alu_muldiv.sv ====
// Iterative shift-add multiplier
`timescale 1ns/100ps
`default_nettype none

`include "exu_alu_config.svh"

module exu_alu_muldiv (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset,
  input  wire logic                    i_valid,
  output logic                         o_ready,
  input  wire exu_alu_pkg::xlen_t      i_rs1,
  input  wire exu_alu_pkg::xlen_t      i_rs2,
  output exu_alu_pkg::dpath_req_t      o_req,
  input  wire exu_alu_pkg::xlen_t      i_res,
  output logic                         o_rsp_valid,
  input  wire logic                    i_o_ready,
  output exu_alu_pkg::unit_rsp_t       o_rsp
);
  import exu_alu_pkg::*;

  mdv_state_e state;
  logic [5:0] step;
  xlen_t      acc;      // Running low product
  xlen_t      mcand;    // Multiplicand shifted left each step
  xlen_t      mplier;   // Multiplier shifted right each step

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= MDV_IDLE;
      step  <= '0;
    end else begin
      case (state)
        MDV_IDLE: begin
          step <= '0;
          if (i_valid) state <= MDV_BUSY;
        end
        MDV_BUSY: begin
          step <= step + 6'd1;
          if (step == 6'(`EXU_MUL_STEPS - 1)) state <= MDV_DONE;
        end
        MDV_DONE: if (i_o_ready) state <= MDV_IDLE;   // Handshake done
        default:  state <= MDV_IDLE;
      endcase
    end
  end

  // Operand registers
  always_ff @(posedge i_clk) begin
    if (state == MDV_IDLE) begin
      acc    <= '0;
      mcand  <= i_rs1;
      mplier <= i_rs2;
    end else if (state == MDV_BUSY) begin
      acc    <= i_res;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // One partial product per step through the shared adder
  assign o_req.op1 = acc;
  assign o_req.op2 = mplier[0] ? mcand : '0;
  assign o_req.fn  = `EXU_DPATH_ADD;

  assign o_rsp_valid = (state == MDV_DONE);
  assign o_ready     = (state == MDV_DONE) & i_o_ready;
  assign o_rsp       = '{wdat: acc, err: 1'b0, bjp: 1'b0, prdt: 1'b0, rslv: 1'b0};

endmodule

`default_nettype wire

// ==== logic/exu_alu_disp.sv ====
// Execution ALU dispatch and result arbiter
`timescale 1ns/100ps
`default_nettype none

`include "exu_alu_config.svh"

module exu_alu_disp (
  input  wire logic                    i_valid,
  output logic                         o_ready,
  input  wire exu_alu_pkg::exu_issue_t i_issue,
  output logic                         o_rglr_valid,
  input  wire logic                    i_rglr_ready,
  input  wire logic                    i_rglr_rsp_valid,
  input  wire exu_alu_pkg::unit_rsp_t  i_rglr_rsp,
  output logic                         o_bjp_valid,
  input  wire logic                    i_bjp_ready,
  input  wire logic                    i_bjp_rsp_valid,
  input  wire exu_alu_pkg::unit_rsp_t  i_bjp_rsp,
  output logic                         o_mdv_valid,
  input  wire logic                    i_mdv_ready,
  input  wire logic                    i_mdv_rsp_valid,
  input  wire exu_alu_pkg::unit_rsp_t  i_mdv_rsp,
  output logic                         o_unit_ready,
  output logic                         o_cmt_valid,
  input  wire logic                    i_cmt_ready,
  output exu_alu_pkg::exu_cmt_t        o_cmt,
  output logic                         o_wbck_valid,
  input  wire logic                    i_wbck_ready,
  output exu_alu_pkg::exu_wbck_t       o_wbck
);
  import exu_alu_pkg::*;

  logic      sel_excp, sel_rglr, sel_bjp, sel_mdv;
  logic      rsp_valid;
  logic      need_wbck;
  unit_rsp_t rsp;

  ////////////////////////////////////////////////////////////////////////////
  // Group decode, illegal wins over any group

  assign sel_excp = i_issue.ilegl;
  assign sel_rglr = ~sel_excp & (i_issue.grp == `EXU_GRP_ALU);
  assign sel_bjp  = ~sel_excp & (i_issue.grp == `EXU_GRP_BJP);
  assign sel_mdv  = ~sel_excp & (i_issue.grp == `EXU_GRP_MUL);

  assign o_rglr_valid = i_valid & sel_rglr;
  assign o_bjp_valid  = i_valid & sel_bjp;
  assign o_mdv_valid  = i_valid & sel_mdv;

  // Illegal path needs no unit, it passes straight through
  assign o_ready = (sel_excp & o_unit_ready)
                 | (sel_rglr & i_rglr_ready)
                 | (sel_bjp  & i_bjp_ready)
                 | (sel_mdv  & i_mdv_ready);

  always_comb begin
    rsp       = '0;
    rsp_valid = 1'b0;
    if (sel_excp) begin
      rsp.err   = 1'b1;                    // wdat stays zero
      rsp_valid = i_valid;
    end else if (sel_rglr) begin
      rsp       = i_rglr_rsp;
      rsp_valid = i_rglr_rsp_valid;
    end else if (sel_bjp) begin
      rsp       = i_bjp_rsp;
      rsp_valid = i_bjp_rsp_valid;
    end else if (sel_mdv) begin
      rsp       = i_mdv_rsp;
      rsp_valid = i_mdv_rsp_valid;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Commit and writeback handshake

  assign need_wbck    = i_issue.rdwen & ~rsp.err;
  assign o_unit_ready = i_cmt_ready & (~need_wbck | i_wbck_ready);

  assign o_cmt_valid  = rsp_valid & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = rsp_valid & need_wbck & i_cmt_ready;

  assign o_cmt.pc     = i_issue.pc;
  assign o_cmt.pc_vld = 1'b1;
  assign o_cmt.bjp    = sel_bjp & rsp.bjp;   // Branch fields only from BJP
  assign o_cmt.prdt   = sel_bjp & rsp.prdt;
  assign o_cmt.rslv   = sel_bjp & rsp.rslv;
  assign o_cmt.ilegl  = i_issue.ilegl;

  assign o_wbck.wdat  = rsp.wdat;
  assign o_wbck.rdidx = i_issue.rdidx;

endmodule

`default_nettype wire

// ==== logic/exu_alu.sv ====
// Execution ALU top
`timescale 1ns/100ps
`default_nettype none

module exu_alu (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset,
  input  wire logic                    i_valid,
  output logic                         o_ready,
  input  wire exu_alu_pkg::exu_issue_t i_issue,
  output logic                         o_cmt_valid,
  input  wire logic                    i_cmt_ready,
  output exu_alu_pkg::exu_cmt_t        o_cmt,
  output logic                         o_wbck_valid,
  input  wire logic                    i_wbck_ready,
  output exu_alu_pkg::exu_wbck_t       o_wbck
);
  import exu_alu_pkg::*;

  logic       rglr_valid, rglr_ready, rglr_rsp_valid;
  logic       bjp_valid, bjp_ready, bjp_rsp_valid;
  logic       mdv_valid, mdv_ready, mdv_rsp_valid;
  logic       unit_ready;
  unit_rsp_t  rglr_rsp, bjp_rsp, mdv_rsp;
  dpath_req_t rglr_req, bjp_req, mdv_req;
  xlen_t      dpath_res;

  exu_alu_disp u_disp (
    .i_valid, .o_ready, .i_issue,
    .o_rglr_valid    (rglr_valid),
    .i_rglr_ready    (rglr_ready),
    .i_rglr_rsp_valid(rglr_rsp_valid),
    .i_rglr_rsp      (rglr_rsp),
    .o_bjp_valid     (bjp_valid),
    .i_bjp_ready     (bjp_ready),
    .i_bjp_rsp_valid (bjp_rsp_valid),
    .i_bjp_rsp       (bjp_rsp),
    .o_mdv_valid     (mdv_valid),
    .i_mdv_ready     (mdv_ready),
    .i_mdv_rsp_valid (mdv_rsp_valid),
    .i_mdv_rsp       (mdv_rsp),
    .o_unit_ready    (unit_ready),
    .o_cmt_valid, .i_cmt_ready, .o_cmt,
    .o_wbck_valid, .i_wbck_ready, .o_wbck
  );

  exu_alu_rglr u_rglr (
    .i_valid(rglr_valid), .o_ready(rglr_ready), .i_op(i_issue.op),
    .i_rs1(i_issue.rs1), .i_rs2(i_issue.rs2), .i_imm(i_issue.imm),
    .o_req(rglr_req), .i_res(dpath_res),
    .o_rsp_valid(rglr_rsp_valid), .i_o_ready(unit_ready), .o_rsp(rglr_rsp)
  );

  exu_alu_bjp u_bjp (
    .i_valid(bjp_valid), .o_ready(bjp_ready), .i_op(i_issue.op),
    .i_rs1(i_issue.rs1), .i_rs2(i_issue.rs2), .i_imm(i_issue.imm), .i_pc(i_issue.pc),
    .o_req(bjp_req), .i_res(dpath_res),
    .o_rsp_valid(bjp_rsp_valid), .i_o_ready(unit_ready), .o_rsp(bjp_rsp)
  );

  exu_alu_muldiv u_muldiv (
    .i_clk, .i_reset,
    .i_valid(mdv_valid), .o_ready(mdv_ready),
    .i_rs1(i_issue.rs1), .i_rs2(i_issue.rs2),
    .o_req(mdv_req), .i_res(dpath_res),
    .o_rsp_valid(mdv_rsp_valid), .i_o_ready(unit_ready), .o_rsp(mdv_rsp)
  );

  exu_alu_dpath u_dpath (
    .i_grp(i_issue.grp),
    .i_rglr_req(rglr_req), .i_bjp_req(bjp_req), .i_mdv_req(mdv_req),
    .o_res(dpath_res)
  );

endmodule

`default_nettype wire

// ==== bench/tb_exu_alu.sv ====
// Execution ALU testbench
`timescale 1ns/100ps
`default_nettype none

`include "exu_alu_config.svh"

module tb_exu_alu;
  import exu_alu_pkg::*;

  localparam int  NUM_INSTR   = 400;
  localparam int  CYCLE_LIMIT = NUM_INSTR * 60;
  localparam int  MUL_LAT     = `EXU_MUL_STEPS + 1;   // Edges from issue to DONE
  localparam op_t IMM_FLAG    = op_t'(1 << `EXU_OP_IMM_BIT);

  logic       i_clk;
  logic       i_reset;
  logic       i_valid;
  logic       o_ready;
  exu_issue_t i_issue;
  logic       o_cmt_valid;
  logic       i_cmt_ready;
  exu_cmt_t   o_cmt;
  logic       o_wbck_valid;
  logic       i_wbck_ready;
  exu_wbck_t  o_wbck;

  integer seed;
  int     cycle_cnt   = 0;
  int     val_errs    = 0;
  int     other_errs  = 0;
  int     done_cnt    = 0;
  int     cmt_hs_cnt  = 0;
  int     wbck_hs_cnt = 0;
  int     wb_exp_cnt  = 0;

  // Expected response of the instruction on the issue port
  xlen_t exp_wdat;
  logic  exp_err, exp_bjp, exp_prdt, exp_rslv, exp_wb;
  int    exp_lat;

  exu_alu DUT (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .i_issue     (i_issue),
    .o_cmt_valid (o_cmt_valid),
    .i_cmt_ready (i_cmt_ready),
    .o_cmt       (o_cmt),
    .o_wbck_valid(o_wbck_valid),
    .i_wbck_ready(i_wbck_ready),
    .o_wbck      (o_wbck)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // Run limit
  always @(posedge i_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d instructions done", cycle_cnt, done_cnt);
      $display("Errors: %0d wrong values, %0d other failures", val_errs, other_errs);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Handshakes seen on the commit and writeback channels
  always @(negedge i_clk) begin
    if (!i_reset) begin
      if (o_cmt_valid === 1'b1 && i_cmt_ready === 1'b1) cmt_hs_cnt++;
      if (o_wbck_valid === 1'b1 && i_wbck_ready === 1'b1) wbck_hs_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic xlen_t alu_result(op_t op, xlen_t rs1, xlen_t rs2, xlen_t imm);
    xlen_t b;
    b = op[`EXU_OP_IMM_BIT] ? imm : rs2;
    case (op)
      `EXU_OP_LUI:             return imm;
      `EXU_OP_SLT:             return ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
      `EXU_OP_SLTU:            return (rs1 < b) ? 32'd1 : 32'd0;
      `EXU_OP_ADD,
      `EXU_OP_ADD | IMM_FLAG:  return rs1 + b;
      `EXU_OP_SUB:             return rs1 - b;
      `EXU_OP_XOR,
      `EXU_OP_XOR | IMM_FLAG:  return rs1 ^ b;
      `EXU_OP_OR,
      `EXU_OP_OR | IMM_FLAG:   return rs1 | b;
      `EXU_OP_AND,
      `EXU_OP_AND | IMM_FLAG:  return rs1 & b;
      `EXU_OP_SLL,
      `EXU_OP_SLL | IMM_FLAG:  return rs1 << b[4:0];
      `EXU_OP_SRL:             return rs1 >> b[4:0];
      `EXU_OP_SRA:             return xlen_t'($signed(rs1) >>> b[4:0]);
      default:                 return '0;
    endcase
  endfunction

  function automatic logic branch_taken(op_t op, xlen_t rs1, xlen_t rs2);
    case (op)
      `EXU_OP_BEQ:  return rs1 == rs2;
      `EXU_OP_BNE:  return rs1 != rs2;
      `EXU_OP_BLT:  return $signed(rs1) < $signed(rs2);
      `EXU_OP_BGE:  return $signed(rs1) >= $signed(rs2);
      `EXU_OP_BLTU: return rs1 < rs2;
      `EXU_OP_BGEU: return rs1 >= rs2;
      default:      return 1'b1;   // jal
    endcase
  endfunction

  task automatic compute_expected();
    exp_wdat = '0;
    exp_err  = 1'b0;
    exp_bjp  = 1'b0;
    exp_prdt = 1'b0;
    exp_rslv = 1'b0;
    exp_lat  = 0;
    if (i_issue.ilegl) begin
      exp_err = 1'b1;
    end else if (i_issue.grp == `EXU_GRP_ALU) begin
      exp_wdat = alu_result(i_issue.op, i_issue.rs1, i_issue.rs2, i_issue.imm);
    end else if (i_issue.grp == `EXU_GRP_BJP) begin
      exp_bjp  = 1'b1;
      exp_prdt = i_issue.imm[`EXU_XLEN-1];
      exp_rslv = branch_taken(i_issue.op, i_issue.rs1, i_issue.rs2);
      exp_wdat = i_issue.pc + 32'd4;                  // Link value
    end else begin
      exp_wdat = i_issue.rs1 * i_issue.rs2;           // Low word only
      exp_lat  = MUL_LAT;
    end
    exp_wb = i_issue.rdwen & ~exp_err;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checks

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      val_errs++;
      $display("Fail time %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic drive_readies();
    i_cmt_ready  = (rand_word() & 3) != 0;
    i_wbck_ready = (rand_word() & 3) != 0;
  endtask

  task automatic make_issue();
    logic [31:0] r;
    i_issue.rs1   = rand_word();
    i_issue.rs2   = ((rand_word() & 3) == 0) ? i_issue.rs1 : rand_word();
    i_issue.imm   = rand_word();
    i_issue.pc    = rand_word() & 32'hffff_fffc;
    r             = rand_word();
    i_issue.rdidx = r[4:0];
    i_issue.rdwen = (rand_word() & 3) != 0;
    i_issue.ilegl = (rand_word() & 15) == 0;
    r             = rand_word();
    case (r[31:0] % 3)
      0: begin
        i_issue.grp = `EXU_GRP_ALU;
        i_issue.op  = op_t'(rand_word() & 15);
      end
      1: begin
        i_issue.grp = `EXU_GRP_BJP;
        i_issue.op  = op_t'({rand_word()} % 7);
      end
      default: begin
        i_issue.grp = `EXU_GRP_MUL;
        i_issue.op  = `EXU_OP_MUL;
      end
    endcase
  endtask

  // Bubble cycle with nothing offered downstream
  task automatic idle_cycle();
    i_valid = 1'b0;
    drive_readies();
    @(negedge i_clk);
    check_val("o_cmt_valid", o_cmt_valid, 1'b0);
    check_val("o_wbck_valid", o_wbck_valid, 1'b0);
    @(posedge i_clk);
    #2;
  endtask

  // Hold one instruction until the handshake and check every cycle
  task automatic issue_and_wait();
    int        k;
    logic      done, down;
    logic      cmt_exp;
    logic      cmt_stall, wbck_stall;
    exu_cmt_t  prev_cmt;
    exu_wbck_t prev_wbck;
    k          = 0;
    done       = 1'b0;
    cmt_stall  = 1'b0;
    wbck_stall = 1'b0;
    i_valid    = 1'b1;
    drive_readies();
    while (!done) begin
      @(negedge i_clk);
      if (cmt_stall) check_val("o_cmt held", o_cmt, prev_cmt);
      if (wbck_stall) check_val("o_wbck held", o_wbck, prev_wbck);
      if (k < exp_lat) begin
        check_val("o_ready", o_ready, 1'b0);
        check_val("o_cmt_valid", o_cmt_valid, 1'b0);
        check_val("o_wbck_valid", o_wbck_valid, 1'b0);
      end else begin
        down    = i_cmt_ready & (~exp_wb | i_wbck_ready);
        cmt_exp = ~exp_wb | i_wbck_ready;
        check_val("o_ready", o_ready, down);
        check_val("o_cmt_valid", o_cmt_valid, cmt_exp);
        check_val("o_wbck_valid", o_wbck_valid, exp_wb & i_cmt_ready);
      end
      if (o_ready) begin
        check_val("o_cmt.pc", o_cmt.pc, i_issue.pc);
        check_val("o_cmt.pc_vld", o_cmt.pc_vld, 1'b1);
        check_val("o_cmt.bjp", o_cmt.bjp, exp_bjp);
        check_val("o_cmt.prdt", o_cmt.prdt, exp_prdt);
        check_val("o_cmt.rslv", o_cmt.rslv, exp_rslv);
        check_val("o_cmt.ilegl", o_cmt.ilegl, i_issue.ilegl);
        if (exp_wb) begin
          check_val("o_wbck.wdat", o_wbck.wdat, exp_wdat);
          check_val("o_wbck.rdidx", o_wbck.rdidx, i_issue.rdidx);
          wb_exp_cnt++;
        end
        done_cnt++;
        done = 1'b1;
      end
      cmt_stall  = o_cmt_valid & ~i_cmt_ready;
      wbck_stall = o_wbck_valid & ~i_wbck_ready;
      prev_cmt   = o_cmt;
      prev_wbck  = o_wbck;
      k++;
      @(posedge i_clk);
      #2;
      if (!done) drive_readies();
    end
  endtask

  initial begin
    seed         = 16191;
    i_reset      = 1'b1;
    i_valid      = 1'b0;
    i_issue      = '0;
    i_cmt_ready  = 1'b0;
    i_wbck_ready = 1'b0;
    repeat (10) @(posedge i_clk);
    #2;
    i_reset = 1'b0;
    idle_cycle();
    for (int n = 0; n < NUM_INSTR; n++) begin
      if ((rand_word() & 7) == 0) idle_cycle();
      make_issue();
      compute_expected();
      issue_and_wait();
    end
    idle_cycle();
    assert (cmt_hs_cnt == NUM_INSTR) else begin
      other_errs++;
      $display("Saw %0d commit handshakes for %0d instructions", cmt_hs_cnt, NUM_INSTR);
    end
    assert (wbck_hs_cnt == wb_exp_cnt) else begin
      other_errs++;
      $display("Saw %0d writeback handshakes where %0d were expected",
               wbck_hs_cnt, wb_exp_cnt);
    end
    $display("Errors: %0d wrong values, %0d other failures", val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
logic/exu_alu_pkg.sv
logic/exu_alu_dpath.sv
logic/exu_alu_rglr.sv
logic/exu_alu_bjp.sv
logic/exu_alu_muldiv.sv
logic/exu_alu_disp.sv
logic/exu_alu.sv
bench/tb_exu_alu.sv
